// File: rtl/rv_decode_cfg.svh
`ifndef RV_DECODE_CFG_SVH
`define RV_DECODE_CFG_SVH

`define XLEN 32            // data and pc width
`define INSN_W 32          // fetched instruction word
`define LG_PRF_ENTRIES 6   // physical register index width

`endif

// File: rtl/rv_isa_pkg.sv
package rv_isa_pkg;

   typedef enum logic [1:0] {
      priv_user       = 2'd0,
      priv_supervisor = 2'd1,
      priv_machine    = 2'd3
   } priv_t;

   localparam logic [6:0] opc_load     = 7'h03;
   localparam logic [6:0] opc_misc_mem = 7'h0f;
   localparam logic [6:0] opc_op_imm   = 7'h13;
   localparam logic [6:0] opc_auipc    = 7'h17;
   localparam logic [6:0] opc_store    = 7'h23;
   localparam logic [6:0] opc_op       = 7'h33;
   localparam logic [6:0] opc_lui      = 7'h37;
   localparam logic [6:0] opc_branch   = 7'h63;
   localparam logic [6:0] opc_jalr     = 7'h67;
   localparam logic [6:0] opc_jal      = 7'h6f;
   localparam logic [6:0] opc_system   = 7'h73;

   localparam logic [6:0] f7_base   = 7'h00;
   localparam logic [6:0] f7_alt    = 7'h20;   // sub and sra
   localparam logic [6:0] f7_muldiv = 7'h01;
   localparam logic [6:0] f7_czero  = 7'h07;

   localparam logic [11:0] sys_sret = 12'h102;
   localparam logic [11:0] sys_mret = 12'h302;

   localparam logic [11:0]
      csr_sstatus = 12'h100, csr_sie = 12'h104, csr_stvec = 12'h105,
      csr_scounteren = 12'h106, csr_sscratch = 12'h140, csr_sepc = 12'h141,
      csr_scause = 12'h142, csr_stval = 12'h143, csr_sip = 12'h144,
      csr_satp = 12'h180, csr_mstatus = 12'h300, csr_misa = 12'h301,
      csr_medeleg = 12'h302, csr_mideleg = 12'h303, csr_mie = 12'h304,
      csr_mtvec = 12'h305, csr_mcounteren = 12'h306, csr_mscratch = 12'h340,
      csr_mepc = 12'h341, csr_mcause = 12'h342, csr_mtval = 12'h343,
      csr_mip = 12'h344, csr_cycle = 12'hc00, csr_instret = 12'hc02,
      csr_mvendorid = 12'hf11, csr_marchid = 12'hf12, csr_mimpid = 12'hf13,
      csr_mhartid = 12'hf14;

   typedef enum logic [6:0] {
      II = 7'd0, NOP = 7'd1, FETCH_PF = 7'd2, IRQ = 7'd3,
      ADDI = 7'd4, SLLI, SLTI, SLTIU, XORI, SRLI, SRAI, ORI, ANDI,
      ADDU = 7'd13, SUBU, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
      MUL = 7'd23, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU, CZEQZ, CZNEZ,
      LUI = 7'd33, AUIPC,
      LB = 7'd35, LH, LW, LBU, LHU,
      SB = 7'd40, SH, SW,
      BEQ = 7'd43, BNE, BLT, BGE, BLTU, BGEU,
      JAL = 7'd49, J, JALR, JR, RET,
      CSRRW = 7'd54, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI, RDCYCLE, RDINSTRET,
      ECALL = 7'd62, EBREAK, SRET, MRET, FENCEI
   } op_t;

   typedef enum logic [5:0] {
      BADCSR = 6'd0, SSTATUS, SIE, STVEC, SCOUNTEREN, SSCRATCH, SEPC, SCAUSE,
      STVAL, SIP, SATP, MSTATUS, MISA, MEDELEG, MIDELEG, MIE, MTVEC, MCOUNTEREN,
      MSCRATCH, MEPC, MCAUSE, MTVAL, MIP, RDCYCLE_CSR, RDINSTRET_CSR,
      MVENDORID, MARCHID, MIMPLID, MHARTID
   } csr_t;

endpackage

// File: rtl/rv_uop_pkg.sv
`include "rv_decode_cfg.svh"

package rv_uop_pkg;

   typedef struct packed {
      rv_isa_pkg::op_t            op;
      logic [`LG_PRF_ENTRIES-1:0] src_a;
      logic [`LG_PRF_ENTRIES-1:0] src_b;
      logic [`LG_PRF_ENTRIES-1:0] dst;
      logic                       src_a_valid;
      logic                       src_b_valid;
      logic                       dst_valid;
      logic [`XLEN-1:0]           rvimm;
      logic [15:0]                imm;          // rs1 field and csr id for csr ops
      logic [`XLEN-1:0]           pc;
      logic                       serializing_op;
      logic                       must_restart;
      logic                       is_br;
      logic                       is_mem;
      logic                       is_int;
      logic                       is_store;
      logic                       is_cheap_int;
   } uop_t;

endpackage

// File: rtl/rv_imm_gen.sv
`timescale 1ns/1ns
`include "rv_decode_cfg.svh"

module rv_imm_gen
(
   input  logic [`INSN_W-1:0] insn,
   input  logic [`XLEN-1:0]   pc,
   output logic [`XLEN-1:0]   rvimm
);
   import rv_isa_pkg::*;

   logic [6:0]       opcode;
   logic [`XLEN-1:0] imm_i;
   logic [`XLEN-1:0] imm_s;
   logic [`XLEN-1:0] imm_u;
   logic [`XLEN-1:0] imm_b;
   logic [`XLEN-1:0] imm_j;
   logic [`XLEN-1:0] pc_off;

   assign opcode = insn[6:0];
   assign imm_i = `XLEN'($signed(insn[31:20]));
   assign imm_s = `XLEN'($signed({insn[31:25], insn[11:7]}));
   assign imm_u = `XLEN'($signed({insn[31:12], 12'd0}));
   assign imm_b = `XLEN'($signed({insn[31], insn[7], insn[30:25], insn[11:8], 1'b0}));
   assign imm_j = `XLEN'($signed({insn[31], insn[19:12], insn[20], insn[30:21], 1'b0}));

   // one adder shared by auipc, branches and jal
   assign pc_off = (opcode == opc_auipc) ? imm_u : (opcode == opc_branch) ? imm_b : imm_j;

   always_comb
   begin
      case (opcode)
         opc_load, opc_op_imm, opc_jalr: rvimm = imm_i;
         opc_store:                      rvimm = imm_s;
         opc_auipc, opc_branch, opc_jal: rvimm = pc + pc_off;
         opc_lui:                        rvimm = imm_u;
         default:                        rvimm = '0;
      endcase
   end

endmodule

// File: rtl/rv_csr_decode.sv
`timescale 1ns/1ns

module rv_csr_decode
(
   input  logic [11:0]       csr_addr,
   input  rv_isa_pkg::priv_t priv,
   output rv_isa_pkg::csr_t  csr_id
);
   import rv_isa_pkg::*;

   csr_t raw_id;

   always_comb
   begin
      case (csr_addr)
         csr_sstatus:    raw_id = SSTATUS;
         csr_sie:        raw_id = SIE;
         csr_stvec:      raw_id = STVEC;
         csr_scounteren: raw_id = SCOUNTEREN;
         csr_sscratch:   raw_id = SSCRATCH;
         csr_sepc:       raw_id = SEPC;
         csr_scause:     raw_id = SCAUSE;
         csr_stval:      raw_id = STVAL;
         csr_sip:        raw_id = SIP;
         csr_satp:       raw_id = SATP;
         csr_mstatus:    raw_id = MSTATUS;
         csr_misa:       raw_id = MISA;
         csr_medeleg:    raw_id = MEDELEG;
         csr_mideleg:    raw_id = MIDELEG;
         csr_mie:        raw_id = MIE;
         csr_mtvec:      raw_id = MTVEC;
         csr_mcounteren: raw_id = MCOUNTEREN;
         csr_mscratch:   raw_id = MSCRATCH;
         csr_mepc:       raw_id = MEPC;
         csr_mcause:     raw_id = MCAUSE;
         csr_mtval:      raw_id = MTVAL;
         csr_mip:        raw_id = MIP;
         csr_cycle:      raw_id = RDCYCLE_CSR;
         csr_instret:    raw_id = RDINSTRET_CSR;
         csr_mvendorid:  raw_id = MVENDORID;
         csr_marchid:    raw_id = MARCHID;
         csr_mimpid:     raw_id = MIMPLID;
         csr_mhartid:    raw_id = MHARTID;
         default:        raw_id = BADCSR;
      endcase
   end

   // bits 9:8 of a csr address hold the lowest privilege allowed to access it
   assign csr_id = (priv < csr_addr[9:8]) ? BADCSR : raw_id;

endmodule

// File: rtl/rv_op_decode.sv
`timescale 1ns/1ns
`include "rv_decode_cfg.svh"

module rv_op_decode
(
   input  logic [`INSN_W-1:0] insn,
   input  logic [`XLEN-1:0]   pc,
   input  rv_isa_pkg::priv_t  priv,
   input  logic               page_fault,
   input  logic               irq,
   input  logic [`XLEN-1:0]   rvimm,
   input  rv_isa_pkg::csr_t   csr_id,
   output rv_uop_pkg::uop_t   uop
);
   import rv_isa_pkg::*;

   localparam int zp = `LG_PRF_ENTRIES - 5;

   logic [6:0]                 opcode;
   logic [2:0]                 funct3;
   logic [6:0]                 funct7;
   logic [`LG_PRF_ENTRIES-1:0] rd;
   logic [`LG_PRF_ENTRIES-1:0] rs1;
   logic [`LG_PRF_ENTRIES-1:0] rs2;
   logic                       rd_zero;
   logic                       rs1_zero;
   logic                       rs1_link;
   logic                       sys_plain;
   logic                       alu_rd0;   // op collapses to NOP when rd is x0

   assign opcode = (page_fault | irq) ? 7'd0 : insn[6:0];
   assign funct3 = insn[14:12];
   assign funct7 = insn[31:25];
   assign rd = {{zp{1'b0}}, insn[11:7]};
   assign rs1 = {{zp{1'b0}}, insn[19:15]};
   assign rs2 = {{zp{1'b0}}, insn[24:20]};
   assign rd_zero = (insn[11:7] == 5'd0);
   assign rs1_zero = (insn[19:15] == 5'd0);
   assign rs1_link = (insn[19:15] == 5'd1) || (insn[19:15] == 5'd5);
   assign sys_plain = (insn[19:7] == 13'd0);   // no register fields

   always_comb
   begin
      uop = '0;
      uop.op = page_fault ? FETCH_PF : (irq ? IRQ : II);
      uop.pc = pc;
      uop.rvimm = rvimm;
      alu_rd0 = 1'b0;
      case (opcode)
         opc_load:
         begin
            uop.dst = rd;
            uop.dst_valid = !rd_zero;
            uop.src_a = rs1;
            uop.src_a_valid = 1'b1;
            uop.is_mem = 1'b1;
            case (funct3)
               3'd0: uop.op = LB;
               3'd1: uop.op = LH;
               3'd2: uop.op = LW;
               3'd4: uop.op = LBU;
               3'd5: uop.op = LHU;
               default: ;
            endcase
         end
         opc_misc_mem:
         begin
            uop.op = NOP;   // plain fence
            if (funct3 == 3'd1)
            begin
               uop.op = FENCEI;
               uop.is_int = 1'b1;
               uop.serializing_op = 1'b1;
               uop.must_restart = 1'b1;
            end
         end
         opc_op_imm:
         begin
            uop.dst = rd;
            uop.dst_valid = !rd_zero;
            uop.src_a = rs1;
            uop.src_a_valid = !rd_zero;
            uop.is_int = 1'b1;
            uop.is_cheap_int = 1'b1;
            alu_rd0 = 1'b1;
            case (funct3)
               3'd0: uop.op = ADDI;
               3'd1: uop.op = (funct7 == f7_base) ? SLLI : II;
               3'd2: uop.op = SLTI;
               3'd3: uop.op = SLTIU;
               3'd4: uop.op = XORI;
               3'd5: uop.op = (funct7 == f7_base) ? SRLI :
                              (funct7 == f7_alt) ? SRAI : II;
               3'd6: uop.op = ORI;
               default: uop.op = ANDI;
            endcase
         end
         opc_auipc, opc_lui:
         begin
            uop.op = (opcode == opc_lui) ? LUI : AUIPC;
            uop.dst = rd;
            uop.dst_valid = !rd_zero;
            uop.is_int = 1'b1;
            uop.is_cheap_int = 1'b1;
            alu_rd0 = 1'b1;
         end
         opc_store:
         begin
            uop.src_a = rs1;
            uop.src_b = rs2;
            uop.src_a_valid = 1'b1;
            uop.src_b_valid = 1'b1;
            uop.is_mem = 1'b1;
            uop.is_store = 1'b1;
            case (funct3)
               3'd0: uop.op = SB;
               3'd1: uop.op = SH;
               3'd2: uop.op = SW;
               default: ;
            endcase
         end
         opc_op:
         begin
            uop.dst = rd;
            uop.dst_valid = !rd_zero;
            uop.src_a = rs1;
            uop.src_b = rs2;
            uop.src_a_valid = 1'b1;
            uop.src_b_valid = 1'b1;
            uop.is_int = 1'b1;
            alu_rd0 = 1'b1;
            case ({funct7, funct3})
               {f7_base, 3'd0}:   uop.op = ADDU;
               {f7_alt, 3'd0}:    uop.op = SUBU;
               {f7_base, 3'd1}:   uop.op = SLL;
               {f7_base, 3'd2}:   uop.op = SLT;
               {f7_base, 3'd3}:   uop.op = SLTU;
               {f7_base, 3'd4}:   uop.op = XOR;
               {f7_base, 3'd5}:   uop.op = SRL;
               {f7_alt, 3'd5}:    uop.op = SRA;
               {f7_base, 3'd6}:   uop.op = OR;
               {f7_base, 3'd7}:   uop.op = AND;
               {f7_muldiv, 3'd0}: uop.op = MUL;
               {f7_muldiv, 3'd1}: uop.op = MULH;
               {f7_muldiv, 3'd2}: uop.op = MULHSU;
               {f7_muldiv, 3'd3}: uop.op = MULHU;
               {f7_muldiv, 3'd4}: uop.op = DIV;
               {f7_muldiv, 3'd5}: uop.op = DIVU;
               {f7_muldiv, 3'd6}: uop.op = REM;
               {f7_muldiv, 3'd7}: uop.op = REMU;
               {f7_czero, 3'd5}:  uop.op = CZEQZ;
               {f7_czero, 3'd7}:  uop.op = CZNEZ;
               default: ;
            endcase
         end
         opc_branch:
         begin
            uop.src_a = rs1;
            uop.src_b = rs2;
            uop.src_a_valid = 1'b1;
            uop.src_b_valid = 1'b1;
            uop.is_int = 1'b1;
            uop.is_br = 1'b1;
            case (funct3)
               3'd0: uop.op = BEQ;
               3'd1: uop.op = BNE;
               3'd4: uop.op = BLT;
               3'd5: uop.op = BGE;
               3'd6: uop.op = BLTU;
               3'd7: uop.op = BGEU;
               default: ;
            endcase
         end
         opc_jalr:
         begin
            uop.src_a = rs1;
            uop.src_a_valid = 1'b1;
            uop.is_int = 1'b1;
            uop.is_br = 1'b1;
            uop.is_cheap_int = 1'b1;
            uop.op = rd_zero ? (rs1_link ? RET : JR) : JALR;
            uop.dst = rd;
            uop.dst_valid = !rd_zero;
         end
         opc_jal:
         begin
            uop.op = rd_zero ? J : JAL;
            uop.dst = rd;
            uop.dst_valid = !rd_zero;
            uop.is_int = 1'b1;
            uop.is_br = 1'b1;
            uop.is_cheap_int = 1'b1;
         end
         opc_system:
         begin
            uop.is_int = 1'b1;
            if (insn[31:7] == 25'd0)
            begin
               uop.op = ECALL;
               uop.serializing_op = 1'b1;
               uop.must_restart = 1'b1;
            end
            else if (insn[31:20] == 12'h001 && sys_plain)
            begin
               uop.op = EBREAK;
               uop.serializing_op = 1'b1;
               uop.must_restart = 1'b1;
            end
            else if ((insn[31:20] == sys_sret || insn[31:20] == sys_mret) && sys_plain)
            begin
               if (insn[29] ? (priv == priv_machine) : (priv != priv_user))
               begin
                  uop.op = insn[29] ? MRET : SRET;
                  uop.serializing_op = 1'b1;
                  uop.must_restart = 1'b1;
                  uop.imm = {10'd0, MSTATUS};   // both rewrite mstatus
               end
            end
            else if (insn[31:20] == 12'h105 && sys_plain)
            begin
               uop.op = NOP;   // wfi
            end
            else
            begin
               uop.imm = {5'd0, insn[19:15], csr_id};
               if (csr_id != BADCSR && funct3[1:0] != 2'd0)
               begin
                  uop.dst = rd;
                  uop.dst_valid = !rd_zero;
                  uop.src_a = rs1;
                  uop.src_a_valid = !funct3[2];   // immediate forms carry uimm in imm
                  uop.serializing_op = 1'b1;
                  uop.must_restart = 1'b1;
                  case (funct3)
                     3'd1: uop.op = CSRRW;
                     3'd2: uop.op = CSRRS;
                     3'd3: uop.op = CSRRC;
                     3'd5: uop.op = CSRRWI;
                     3'd6: uop.op = CSRRSI;
                     default: uop.op = CSRRCI;
                  endcase
                  if (funct3 == 3'd2 && rs1_zero)   // pure csr read
                  begin
                     uop.src_a_valid = 1'b0;
                     if (csr_id inside {MVENDORID, MARCHID, MIMPLID, MHARTID})
                     begin
                        uop.op = ADDU;   // id registers read as zero
                        uop.src_a_valid = 1'b1;
                        uop.src_b_valid = 1'b1;
                        uop.serializing_op = 1'b0;
                        uop.must_restart = 1'b0;
                        alu_rd0 = 1'b1;
                     end
                     else if (csr_id == RDCYCLE_CSR || csr_id == RDINSTRET_CSR)
                     begin
                        uop.op = (csr_id == RDCYCLE_CSR) ? RDCYCLE : RDINSTRET;
                        uop.must_restart = 1'b0;
                        alu_rd0 = 1'b1;
                     end
                  end
               end
            end
         end
         default: ;
      endcase
      if (alu_rd0 && rd_zero && uop.op != II)
      begin
         uop.op = NOP;
      end
   end

endmodule

// File: rtl/rv_decode.sv
`timescale 1ns/1ns
`include "rv_decode_cfg.svh"

module rv_decode
(
   input  logic               clk,
   input  logic               arst_n,
   input  logic               insn_valid,
   input  logic [`INSN_W-1:0] insn,
   input  logic [`XLEN-1:0]   pc,
   input  rv_isa_pkg::priv_t  priv,
   input  logic               page_fault,
   input  logic               irq,
   output logic               uop_valid,
   output rv_uop_pkg::uop_t   uop
);
   import rv_isa_pkg::*;
   import rv_uop_pkg::*;

   logic [`XLEN-1:0] rvimm;
   csr_t             csr_id;
   uop_t             uop_next;   // combinational decode result

   rv_imm_gen u_imm_gen
   (
      .insn  (insn),
      .pc    (pc),
      .rvimm (rvimm)
   );

   rv_csr_decode u_csr_decode
   (
      .csr_addr (insn[31:20]),
      .priv     (priv),
      .csr_id   (csr_id)
   );

   rv_op_decode u_op_decode
   (
      .insn       (insn),
      .pc         (pc),
      .priv       (priv),
      .page_fault (page_fault),
      .irq        (irq),
      .rvimm      (rvimm),
      .csr_id     (csr_id),
      .uop        (uop_next)
   );

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         uop_valid <= 1'b0;
         uop <= '0;
      end
      else
      begin
         uop_valid <= insn_valid;
         if (insn_valid)
         begin
            uop <= uop_next;   // holds while idle
         end
      end
   end

endmodule

// File: verification/clk_gen.sv
`timescale 1ns/1ns

module clk_gen
#(
   parameter int period = 8,
   parameter int reset_cycles = 8
)
(
   output logic clk,
   output logic arst_n
);
   initial
   begin
      clk = 1'b0;
      arst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;   // release between edges
   end

   always #(period / 2) clk = ~clk;

endmodule

// File: verification/rv_decode_tb.sv
`timescale 1ns/1ns
`include "rv_decode_cfg.svh"

module rv_decode_tb;
   import rv_isa_pkg::*;
   import rv_uop_pkg::*;

   localparam int num_cases = 28;
   localparam int num_fields = 19;
   localparam int num_random = 64;
   localparam int clk_period = 8;

   logic               clk;
   logic               arst_n;
   logic               insn_valid;
   logic [`INSN_W-1:0] insn;
   logic [`XLEN-1:0]   pc;
   priv_t              priv;
   logic               page_fault;
   logic               irq;
   logic               uop_valid;
   uop_t               uop;

   logic [31:0] case_mem [0:num_cases*num_fields];   // word 0 is the case count
   logic [4:0]  rnd_rd [0:num_random-1];
   logic [4:0]  rnd_rs1 [0:num_random-1];
   logic [4:0]  rnd_rs2 [0:num_random-1];
   op_t         rnd_op [0:num_random-1];
   int          errors;
   int          checks;
   int          case_errors;
   int unsigned seed_val;

   clk_gen #(.period(clk_period), .reset_cycles(8)) u_clk_gen
   (
      .clk    (clk),
      .arst_n (arst_n)
   );

   rv_decode UUT
   (
      .clk        (clk),
      .arst_n     (arst_n),
      .insn_valid (insn_valid),
      .insn       (insn),
      .pc         (pc),
      .priv       (priv),
      .page_fault (page_fault),
      .irq        (irq),
      .uop_valid  (uop_valid),
      .uop        (uop)
   );

   task automatic compare_field(input int idx, input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         case_errors++;
         $display("FAILED %0t: item %0d %s is %h, expected %h", $time, idx, name, got, exp);
      end
   endtask

   // expected R-type op from the ISA table
   function automatic op_t expected_alu_op(input logic [2:0] f3, input logic alt,
                                           input logic [4:0] rd);
      op_t op;
      case (f3)
         3'd0: op = alt ? SUBU : ADDU;
         3'd1: op = SLL;
         3'd2: op = SLT;
         3'd3: op = SLTU;
         3'd4: op = XOR;
         3'd5: op = alt ? SRA : SRL;
         3'd6: op = OR;
         default: op = AND;
      endcase
      if (rd == 5'd0)
      begin
         op = NOP;
      end
      return op;
   endfunction

   task automatic run_case(input int n);
      int          base;
      logic [31:0] exp_op;
      logic [31:0] case_insn;
      logic        exp_cheap;
      base = 1 + n * num_fields;
      exp_op = case_mem[base + 5];
      case_insn = case_mem[base];
      case (case_insn[6:0])
         opc_op_imm, opc_lui, opc_auipc, opc_jalr, opc_jal: exp_cheap = 1'b1;
         default: exp_cheap = 1'b0;
      endcase
      if (case_mem[base + 3][0] || case_mem[base + 4][0])
      begin
         exp_cheap = 1'b0;   // no decode on a fault
      end
      @(posedge clk);
      insn <= case_mem[base];
      pc <= case_mem[base + 1];
      priv <= priv_t'(case_mem[base + 2][1:0]);
      page_fault <= case_mem[base + 3][0];
      irq <= case_mem[base + 4][0];
      insn_valid <= 1'b1;
      @(posedge clk);
      insn_valid <= 1'b0;
      page_fault <= 1'b0;
      irq <= 1'b0;
      @(negedge clk);
      case_errors = 0;
      compare_field(n, "uop_valid", uop_valid, 32'd1);
      compare_field(n, "op", uop.op, exp_op);
      compare_field(n, "dst", uop.dst, case_mem[base + 6]);
      compare_field(n, "dst_valid", uop.dst_valid, case_mem[base + 7]);
      compare_field(n, "src_a", uop.src_a, case_mem[base + 8]);
      compare_field(n, "src_a_valid", uop.src_a_valid, case_mem[base + 9]);
      compare_field(n, "src_b", uop.src_b, case_mem[base + 10]);
      compare_field(n, "src_b_valid", uop.src_b_valid, case_mem[base + 11]);
      if (exp_op != FETCH_PF && exp_op != IRQ)
      begin
         compare_field(n, "rvimm", uop.rvimm, case_mem[base + 12]);
      end
      compare_field(n, "imm", uop.imm, case_mem[base + 13]);
      compare_field(n, "serializing_op", uop.serializing_op, case_mem[base + 14]);
      compare_field(n, "must_restart", uop.must_restart, case_mem[base + 15]);
      compare_field(n, "is_br", uop.is_br, case_mem[base + 16]);
      compare_field(n, "is_mem", uop.is_mem, case_mem[base + 17]);
      compare_field(n, "is_store", uop.is_store, case_mem[base + 18]);
      compare_field(n, "is_cheap_int", uop.is_cheap_int, exp_cheap);
      compare_field(n, "pc", uop.pc, case_mem[base + 1]);
      $display("case %0d done, %0d mismatches", n, case_errors);
   endtask

   task automatic check_stream_item(input int j);
      logic [4:0] rd;
      rd = rnd_rd[j];
      compare_field(j, "uop_valid", uop_valid, 32'd1);
      compare_field(j, "op", uop.op, rnd_op[j]);
      compare_field(j, "dst", uop.dst, rd);
      compare_field(j, "dst_valid", uop.dst_valid, rd != 5'd0);
      compare_field(j, "src_a", uop.src_a, rnd_rs1[j]);
      compare_field(j, "src_a_valid", uop.src_a_valid, 32'd1);
      compare_field(j, "src_b", uop.src_b, rnd_rs2[j]);
      compare_field(j, "src_b_valid", uop.src_b_valid, 32'd1);
      compare_field(j, "rvimm", uop.rvimm, 32'd0);
      compare_field(j, "is_int", uop.is_int, 32'd1);
      compare_field(j, "is_cheap_int", uop.is_cheap_int, 32'd0);
      compare_field(j, "pc", uop.pc, 32'h8000 + 4 * j);
   endtask

   task automatic run_stream();
      logic [2:0] f3;
      logic       alt;
      int         k;
      case_errors = 0;
      for (k = 0; k <= num_random; k++)
      begin
         @(posedge clk);
         if (k < num_random)
         begin
            f3 = 3'($urandom % 8);
            alt = (f3 == 3'd0 || f3 == 3'd5) ? 1'($urandom % 2) : 1'b0;
            rnd_rd[k] = 5'($urandom);
            rnd_rs1[k] = 5'($urandom);
            rnd_rs2[k] = 5'($urandom);
            rnd_op[k] = expected_alu_op(f3, alt, rnd_rd[k]);
            insn <= {alt ? f7_alt : f7_base, rnd_rs2[k], rnd_rs1[k], f3, rnd_rd[k], opc_op};
            pc <= 32'h8000 + 32'(4 * k);
            insn_valid <= 1'b1;
         end
         else
         begin
            insn_valid <= 1'b0;
         end
         @(negedge clk);
         if (k > 0)
         begin
            check_stream_item(k - 1);   // previous item lands one cycle later
         end
      end
      $display("random stream done, %0d mismatches", case_errors);
   endtask

   initial
   begin
      #((num_cases + num_random + 20) * clk_period * 2);
      $display("watchdog timeout, the test did not finish in time");
      $display("sim failed");
      $finish;
   end

   initial
   begin
      insn_valid = 1'b0;
      insn = '0;
      pc = '0;
      priv = priv_machine;
      page_fault = 1'b0;
      irq = 1'b0;
      errors = 0;
      checks = 0;
      seed_val = 32'h0d627848;
      void'($urandom(seed_val));
      $readmemh("verification/rv_decode_cases.txt", case_mem);
      if (case_mem[0] !== num_cases)
      begin
         errors++;
         $display("case file holds %0d cases, but %0d were expected", case_mem[0], num_cases);
      end

      case_errors = 0;
      @(negedge clk);
      compare_field(0, "uop_valid in reset", uop_valid, 32'd0);
      wait (arst_n === 1'b1);
      @(posedge clk);
      @(negedge clk);
      compare_field(0, "uop_valid after reset", uop_valid, 32'd0);
      checks++;
      if (uop !== '0)
      begin
         errors++;
         case_errors++;
         $display("FAILED %0t: uop is not zero after reset", $time);
      end
      $display("reset done, %0d mismatches", case_errors);

      for (int n = 0; n < num_cases; n++)
      begin
         run_case(n);
      end
      run_stream();

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
      begin
         $display("sim passed");
      end
      else
      begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// File: rv_decode.f
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/rv_uop_pkg.sv
rtl/rv_imm_gen.sv
rtl/rv_csr_decode.sv
rtl/rv_op_decode.sv
rtl/rv_decode.sv
verification/clk_gen.sv
verification/rv_decode_tb.sv

// File: verification/rv_decode_cases.txt
// insn pc priv page_fault irq | op dst dst_valid src_a src_a_valid src_b src_b_valid
// rvimm imm serializing_op must_restart is_br is_mem is_store ; first word is the case count
1c
ffd30293 00001000 3 0 0 04 05 1 06 1 00 0 fffffffd 0000 0 0 0 0 0
00108013 00001004 3 0 0 01 00 0 01 0 00 0 00000001 0000 0 0 0 0 0
40445393 00001008 3 0 0 0a 07 1 08 1 00 0 00000404 0000 0 0 0 0 0
40c58533 0000100c 3 0 0 0e 0a 1 0b 1 0c 1 00000000 0000 0 0 0 0 0
023100b3 00001010 3 0 0 17 01 1 02 1 03 1 00000000 0000 0 0 0 0 0
0262d233 00001014 3 0 0 1c 04 1 05 1 06 1 00000000 0000 0 0 0 0 0
0ea4d433 00001018 3 0 0 1f 08 1 09 1 0a 1 00000000 0000 0 0 0 0 0
123457b7 0000101c 3 0 0 21 0f 1 00 0 00 0 12345000 0000 0 0 0 0 0
fffff197 00002000 3 0 0 22 03 1 00 0 00 0 00001000 0000 0 0 0 0 0
00812483 00002004 3 0 0 25 09 1 02 1 00 0 00000008 0000 0 0 0 1 0
ffe3d303 00002008 3 0 0 27 06 1 07 1 00 0 fffffffe 0000 0 0 0 1 0
fe542e23 0000200c 3 0 0 2a 00 0 08 1 05 1 fffffffc 0000 0 0 0 1 1
00208863 00003000 3 0 0 2b 00 0 01 1 02 1 00003010 0000 0 0 1 0 0
fe419ce3 00003000 3 0 0 2c 00 0 03 1 04 1 00002ff8 0000 0 0 1 0 0
001000ef 00004000 3 0 0 31 01 1 00 0 00 0 00004800 0000 0 0 1 0 0
ffdff06f 00004000 3 0 0 32 00 0 00 0 00 0 00003ffc 0000 0 0 1 0 0
00c300e7 00004004 3 0 0 33 01 1 06 1 00 0 0000000c 0000 0 0 1 0 0
00038067 00004008 3 0 0 34 00 0 07 1 00 0 00000000 0000 0 0 1 0 0
00008067 0000400c 3 0 0 35 00 0 01 1 00 0 00000000 0000 0 0 1 0 0
300312f3 00005000 3 0 0 36 05 1 06 1 00 0 00000000 018b 1 1 0 0 0
300312f3 00005004 0 0 0 00 00 0 00 0 00 0 00000000 0180 0 0 0 0 0
c0002573 00005008 0 0 0 3c 0a 1 00 0 00 0 00000000 0017 1 0 0 0 0
30200073 0000500c 1 0 0 00 00 0 00 0 00 0 00000000 0000 0 0 0 0 0
30200073 00005010 3 0 0 41 00 0 00 0 00 0 00000000 000b 1 1 0 0 0
00000073 00005014 0 0 0 3e 00 0 00 0 00 0 00000000 0000 1 1 0 0 0
ffd30293 00006000 3 1 0 02 00 0 00 0 00 0 00000000 0000 0 0 0 0 0
00812483 00006004 3 0 1 03 00 0 00 0 00 0 00000000 0000 0 0 0 0 0
00000073 00006008 3 1 1 02 00 0 00 0 00 0 00000000 0000 0 0 0 0 0
